/* flist.f */
hw/rv_types_pkg.sv
hw/lsu_cfg_pkg.sv
hw/instr_receiver.sv
hw/wb_control.sv
hw/data_memory_unit.sv
hw/arch_state.sv
hw/commit_sender.sv
hw/wb_subsystem.sv
test/wb_subsystem_properties.sv
test/wb_subsystem_tb.sv

/* hw/arch_state.sv */
`timescale 1ns/1ps
`default_nettype none

module arch_state (
    input  wire                       clock,
    input  wire                       reset,
    input  wire                       state_we_i,
    input  wire                       rd_we_i,
    input  rv_types_pkg::reg_idx_t    rd_i,
    input  wire                       is_mem_i,
    input  wire                       is_store_i,
    input  rv_types_pkg::xlen_t       load_data_i,
    input  rv_types_pkg::xlen_t       reg_wdata_i,
    input  rv_types_pkg::csr_op_e     csr_op_i,
    input  rv_types_pkg::csr_sel_t    csr_sel_i,
    input  rv_types_pkg::xlen_t       csr_wdata_i,
    input  rv_types_pkg::reg_idx_t    rs_idx_i,
    output rv_types_pkg::xlen_t       rs_data_o,
    output rv_types_pkg::xlen_t       rd_value_o
);

    import rv_types_pkg::*;

    xlen_t regs_q [num_regs];
    xlen_t csrs_q [num_csrs];
    xlen_t csr_old;
    xlen_t csr_new;
    xlen_t result;
    logic  is_load;

    assign is_load = is_mem_i && !is_store_i;
    assign csr_old = csrs_q[csr_sel_i];

    // csr read-modify-write
    always_comb begin
        case (csr_op_i)
            csr_write: csr_new = csr_wdata_i;
            csr_set:   csr_new = csr_old | csr_wdata_i;
            csr_clear: csr_new = csr_old & ~csr_wdata_i;
            default:   csr_new = csr_old;
        endcase
    end

    // rd gets the old csr value on csr ops
    always_comb begin
        if (is_load) begin
            result = load_data_i;
        end else if (csr_op_i != csr_none) begin
            result = csr_old;
        end else begin
            result = reg_wdata_i;
        end
    end

    assign rd_value_o = result;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs_q[i] <= '0;
            end
            for (int j = 0; j < num_csrs; j++) begin
                csrs_q[j] <= '0;
            end
        end else if (state_we_i) begin
            // x0 is hardwired
            if (rd_we_i && rd_i != '0) begin
                regs_q[rd_i] <= result;
            end
            if (csr_op_i != csr_none) begin
                csrs_q[csr_sel_i] <= csr_new;
            end
        end
    end

    // read port for execute
    assign rs_data_o = (rs_idx_i == '0) ? '0 : regs_q[rs_idx_i];

endmodule

`default_nettype wire

/* hw/commit_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_sender (
    input  wire                       clock,
    input  wire                       reset,
    input  wire                       state_we_i,
    input  wire                       rd_we_i,
    input  rv_types_pkg::reg_idx_t    rd_i,
    input  rv_types_pkg::xlen_t       rd_value_i,
    output logic                      commit_req_o,
    input  wire                       commit_ack_i,
    output logic                      commit_rd_we_o,
    output rv_types_pkg::reg_idx_t    commit_rd_o,
    output rv_types_pkg::xlen_t       commit_value_o,
    output logic                      commit_done_o
);

    typedef enum logic [1:0] {
        tx_idle,
        tx_req,
        tx_drop
    } tx_state_e;

    tx_state_e state_q;

    // snapshot of the retired result, held through the handshake
    always_ff @(posedge clock) begin
        if (state_we_i) begin
            commit_rd_we_o <= rd_we_i;
            commit_rd_o    <= rd_i;
            commit_value_o <= rd_value_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= tx_idle;
        end else begin
            case (state_q)
                tx_idle: begin
                    if (state_we_i) begin
                        state_q <= tx_req;
                    end
                end
                tx_req: begin
                    if (commit_ack_i) begin
                        state_q <= tx_drop;
                    end
                end
                tx_drop: begin
                    // monitor releases ack
                    if (!commit_ack_i) begin
                        state_q <= tx_idle;
                    end
                end
                default: state_q <= tx_idle;
            endcase
        end
    end

    assign commit_req_o  = (state_q == tx_req);
    assign commit_done_o = (state_q == tx_drop) && !commit_ack_i;

endmodule

`default_nettype wire

/* hw/data_memory_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory_unit (
    input  wire                       clock,
    input  wire                       reset,
    input  wire                       mem_start_i,
    input  wire                       is_store_i,
    input  lsu_cfg_pkg::mem_addr_t    mem_addr_i,
    input  rv_types_pkg::xlen_t       store_data_i,
    output logic                      mem_done_o,
    output rv_types_pkg::xlen_t       load_data_o
);

    import rv_types_pkg::*;
    import lsu_cfg_pkg::*;

    xlen_t    ram_q [mem_words];
    xlen_t    load_q;
    logic     busy_q;
    lat_cnt_t cnt_q;

    // cnt_q counts cycles since the start pulse
    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (mem_start_i) begin
            busy_q <= 1'b1;
            cnt_q  <= lat_cnt_t'(1);
        end else if (busy_q) begin
            if (mem_done_o) begin
                busy_q <= 1'b0;
                cnt_q  <= '0;
            end else begin
                cnt_q <= cnt_q + lat_cnt_t'(1);
            end
        end
    end

    assign mem_done_o = busy_q && (cnt_q == lat_cnt_t'(mem_latency));

    // store lands in the done cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                ram_q[i] <= '0;
            end
        end else if (mem_done_o && is_store_i) begin
            ram_q[mem_addr_i] <= store_data_i;
        end
    end

    // read one edge early so data is valid with done, held afterwards
    always_ff @(posedge clock) begin
        if (busy_q && !is_store_i && cnt_q == lat_cnt_t'(mem_latency - 1)) begin
            load_q <= ram_q[mem_addr_i];
        end
    end

    assign load_data_o = load_q;

endmodule

`default_nettype wire

/* hw/instr_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_receiver (
    input  wire                       clock,
    input  wire                       reset,
    input  wire                       req_i,
    output logic                      ack_o,
    input  wire                       rd_we_i,
    input  rv_types_pkg::reg_idx_t    rd_i,
    input  rv_types_pkg::xlen_t       reg_wdata_i,
    input  rv_types_pkg::csr_op_e     csr_op_i,
    input  rv_types_pkg::csr_sel_t    csr_sel_i,
    input  rv_types_pkg::xlen_t       csr_wdata_i,
    input  wire                       is_mem_i,
    input  wire                       is_store_i,
    input  lsu_cfg_pkg::mem_addr_t    mem_addr_i,
    input  rv_types_pkg::xlen_t       store_data_i,
    input  wire                       instr_done_i,
    output logic                      instr_valid_o,
    output logic                      rd_we_o,
    output rv_types_pkg::reg_idx_t    rd_o,
    output rv_types_pkg::xlen_t       reg_wdata_o,
    output rv_types_pkg::csr_op_e     csr_op_o,
    output rv_types_pkg::csr_sel_t    csr_sel_o,
    output rv_types_pkg::xlen_t       csr_wdata_o,
    output logic                      is_mem_o,
    output logic                      is_store_o,
    output lsu_cfg_pkg::mem_addr_t    mem_addr_o,
    output rv_types_pkg::xlen_t       store_data_o
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_busy,
        rx_release
    } rx_state_e;

    rx_state_e state_q;

    // record only taken while idle
    always_ff @(posedge clock) begin
        if (state_q == rx_idle && req_i) begin
            rd_we_o      <= rd_we_i;
            rd_o         <= rd_i;
            reg_wdata_o  <= reg_wdata_i;
            csr_op_o     <= csr_op_i;
            csr_sel_o    <= csr_sel_i;
            csr_wdata_o  <= csr_wdata_i;
            is_mem_o     <= is_mem_i;
            is_store_o   <= is_store_i;
            mem_addr_o   <= mem_addr_i;
            store_data_o <= store_data_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= rx_idle;
            ack_o   <= 1'b0;
        end else begin
            case (state_q)
                rx_idle: begin
                    if (req_i) begin
                        state_q <= rx_busy;
                    end
                end
                rx_busy: begin
                    // ack one cycle after the latch
                    ack_o <= 1'b1;
                    if (instr_done_i) begin
                        state_q <= rx_release;
                    end
                end
                rx_release: begin
                    // close the handshake once req has dropped
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= rx_idle;
                    end
                end
                default: state_q <= rx_idle;
            endcase
        end
    end

    assign instr_valid_o = (state_q == rx_busy);

endmodule

`default_nettype wire

/* hw/lsu_cfg_pkg.sv */
`default_nettype none

package lsu_cfg_pkg;

    localparam int mem_words = 64;
    localparam int mem_addr_w = $clog2(mem_words);
    // access latency in cycles, start pulse to done pulse
    localparam int mem_latency = 3;

    // word address, byte address bits 7:2
    typedef logic [mem_addr_w-1:0] mem_addr_t;
    typedef logic [$clog2(mem_latency+1)-1:0] lat_cnt_t;

endpackage

`default_nettype wire

/* hw/rv_types_pkg.sv */
`default_nettype none

package rv_types_pkg;

    // word width of the core
    localparam int xlen = 32;

    // general register file geometry
    localparam int num_regs = 32;
    localparam int reg_idx_w = $clog2(num_regs);

    // machine CSRs kept by this core
    // 0 mstatus, 1 mtvec, 2 mepc, 3 mscratch
    localparam int num_csrs = 4;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [$clog2(num_csrs)-1:0] csr_sel_t;

    typedef enum logic [2:0] {
        csr_none  = 3'd0,
        csr_write = 3'd1,
        csr_set   = 3'd2,
        csr_clear = 3'd3
    } csr_op_e;

    // writeback sequencing, also watched by the bound checks
    typedef enum logic [2:0] {
        wait_instr  = 3'd0,
        check_kind  = 3'd1,
        wait_mem    = 3'd2,
        write_back  = 3'd3,
        wait_retire = 3'd4
    } wb_state_e;

endpackage

`default_nettype wire

/* hw/wb_control.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_control (
    input  wire  clock,
    input  wire  reset,
    input  wire  instr_valid_i,
    input  wire  is_mem_i,
    input  wire  mem_done_i,
    input  wire  commit_done_i,
    output logic mem_start_o,
    output logic state_we_o,
    output logic instr_done_o
);

    import rv_types_pkg::*;

    wb_state_e state_q;
    wb_state_e state_d;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= wait_instr;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            wait_instr: begin
                if (instr_valid_i) begin
                    state_d = check_kind;
                end
            end
            check_kind: begin
                // loads and stores go through the memory unit first
                if (is_mem_i) begin
                    state_d = wait_mem;
                end else begin
                    state_d = write_back;
                end
            end
            wait_mem: begin
                if (mem_done_i) begin
                    state_d = write_back;
                end
            end
            write_back: begin
                state_d = wait_retire;
            end
            wait_retire: begin
                // held here by a slow retire monitor
                if (commit_done_i) begin
                    state_d = wait_instr;
                end
            end
            default: state_d = wait_instr;
        endcase
    end

    assign mem_start_o  = (state_q == check_kind) && is_mem_i;
    assign state_we_o   = (state_q == write_back);
    assign instr_done_o = (state_q == wait_retire) && commit_done_i;

endmodule

`default_nettype wire

/* hw/wb_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_subsystem (
    input  wire                       clock,
    input  wire                       reset,
    input  wire                       req_i,
    output logic                      ack_o,
    input  wire                       rd_we_i,
    input  rv_types_pkg::reg_idx_t    rd_i,
    input  rv_types_pkg::xlen_t       reg_wdata_i,
    input  rv_types_pkg::csr_op_e     csr_op_i,
    input  rv_types_pkg::csr_sel_t    csr_sel_i,
    input  rv_types_pkg::xlen_t       csr_wdata_i,
    input  wire                       is_mem_i,
    input  wire                       is_store_i,
    input  lsu_cfg_pkg::mem_addr_t    mem_addr_i,
    input  rv_types_pkg::xlen_t       store_data_i,
    input  rv_types_pkg::reg_idx_t    rs_idx_i,
    output rv_types_pkg::xlen_t       rs_data_o,
    output logic                      commit_req_o,
    input  wire                       commit_ack_i,
    output logic                      commit_rd_we_o,
    output rv_types_pkg::reg_idx_t    commit_rd_o,
    output rv_types_pkg::xlen_t       commit_value_o
);

    import rv_types_pkg::*;
    import lsu_cfg_pkg::*;

    // held instruction record
    logic      instr_valid;
    logic      rd_we;
    reg_idx_t  rd;
    xlen_t     reg_wdata;
    csr_op_e   csr_op;
    csr_sel_t  csr_sel;
    xlen_t     csr_wdata;
    logic      is_mem;
    logic      is_store;
    mem_addr_t mem_addr;
    xlen_t     store_data;

    // sequencing strobes
    logic      instr_done;
    logic      mem_start;
    logic      mem_done;
    logic      state_we;
    logic      commit_done;
    xlen_t     load_data;
    xlen_t     rd_value;

    instr_receiver u_instr_receiver (
        .clock        (clock),
        .reset        (reset),
        .req_i        (req_i),
        .ack_o        (ack_o),
        .rd_we_i      (rd_we_i),
        .rd_i         (rd_i),
        .reg_wdata_i  (reg_wdata_i),
        .csr_op_i     (csr_op_i),
        .csr_sel_i    (csr_sel_i),
        .csr_wdata_i  (csr_wdata_i),
        .is_mem_i     (is_mem_i),
        .is_store_i   (is_store_i),
        .mem_addr_i   (mem_addr_i),
        .store_data_i (store_data_i),
        .instr_done_i (instr_done),
        .instr_valid_o(instr_valid),
        .rd_we_o      (rd_we),
        .rd_o         (rd),
        .reg_wdata_o  (reg_wdata),
        .csr_op_o     (csr_op),
        .csr_sel_o    (csr_sel),
        .csr_wdata_o  (csr_wdata),
        .is_mem_o     (is_mem),
        .is_store_o   (is_store),
        .mem_addr_o   (mem_addr),
        .store_data_o (store_data)
    );

    wb_control u_wb_control (
        .clock        (clock),
        .reset        (reset),
        .instr_valid_i(instr_valid),
        .is_mem_i     (is_mem),
        .mem_done_i   (mem_done),
        .commit_done_i(commit_done),
        .mem_start_o  (mem_start),
        .state_we_o   (state_we),
        .instr_done_o (instr_done)
    );

    data_memory_unit u_data_memory_unit (
        .clock       (clock),
        .reset       (reset),
        .mem_start_i (mem_start),
        .is_store_i  (is_store),
        .mem_addr_i  (mem_addr),
        .store_data_i(store_data),
        .mem_done_o  (mem_done),
        .load_data_o (load_data)
    );

    arch_state u_arch_state (
        .clock      (clock),
        .reset      (reset),
        .state_we_i (state_we),
        .rd_we_i    (rd_we),
        .rd_i       (rd),
        .is_mem_i   (is_mem),
        .is_store_i (is_store),
        .load_data_i(load_data),
        .reg_wdata_i(reg_wdata),
        .csr_op_i   (csr_op),
        .csr_sel_i  (csr_sel),
        .csr_wdata_i(csr_wdata),
        .rs_idx_i   (rs_idx_i),
        .rs_data_o  (rs_data_o),
        .rd_value_o (rd_value)
    );

    commit_sender u_commit_sender (
        .clock         (clock),
        .reset         (reset),
        .state_we_i    (state_we),
        .rd_we_i       (rd_we),
        .rd_i          (rd),
        .rd_value_i    (rd_value),
        .commit_req_o  (commit_req_o),
        .commit_ack_i  (commit_ack_i),
        .commit_rd_we_o(commit_rd_we_o),
        .commit_rd_o   (commit_rd_o),
        .commit_value_o(commit_value_o),
        .commit_done_o (commit_done)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the writeback testbench with Verilator, run from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert --top-module wb_subsystem_tb -f flist.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vwb_subsystem_tb > sim.log 2>&1 \
    || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "simulation FAILED, no pass line"; exit 1; }
echo "simulation PASSED"
exit 0

/* test/wb_subsystem_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_subsystem_properties (
    input  wire                       clock,
    input  wire                       reset,
    input  wire                       req_i,
    input  wire                       ack_i,
    input  wire                       instr_valid_i,
    input  wire                       commit_req_i,
    input  wire                       commit_ack_i,
    input  wire                       state_we_i,
    input  rv_types_pkg::wb_state_e   wb_state_i
);

    import rv_types_pkg::*;

    ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(ack_i) |-> req_i)
        else $error("ack rose while req was low");

    // master keeps commit_req up until the monitor answers
    commit_req_held: assert property (@(posedge clock) disable iff (reset)
        commit_req_i && !commit_ack_i |=> commit_req_i)
        else $error("commit_req dropped before commit_ack");

    state_we_single: assert property (@(posedge clock) disable iff (reset)
        state_we_i |=> !state_we_i)
        else $error("state_we lasted more than one cycle");

    // the write uses the record that the receiver still holds
    state_we_in_write_back: assert property (@(posedge clock) disable iff (reset)
        state_we_i |-> wb_state_i == write_back && instr_valid_i)
        else $error("state_we outside write_back or without a held instruction");

endmodule

bind wb_subsystem wb_subsystem_properties u_wb_subsystem_properties (
    .clock        (clock),
    .reset        (reset),
    .req_i        (req_i),
    .ack_i        (ack_o),
    .instr_valid_i(instr_valid),
    .commit_req_i (commit_req_o),
    .commit_ack_i (commit_ack_i),
    .state_we_i   (state_we),
    .wb_state_i   (u_wb_control.state_q)
);

`default_nettype wire

/* test/wb_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_subsystem_tb;

    import rv_types_pkg::*;
    import lsu_cfg_pkg::*;

    localparam int rec_words = 15;
    localparam int max_words = 512;
    localparam int cycles_per_record = 40;

    logic        clock;
    logic        reset;
    logic        req_i;
    logic        ack_o;
    logic        rd_we_i;
    reg_idx_t    rd_i;
    xlen_t       reg_wdata_i;
    csr_op_e     csr_op_i;
    csr_sel_t    csr_sel_i;
    xlen_t       csr_wdata_i;
    logic        is_mem_i;
    logic        is_store_i;
    mem_addr_t   mem_addr_i;
    xlen_t       store_data_i;
    reg_idx_t    rs_idx_i;
    xlen_t       rs_data_o;
    logic        commit_req_o;
    logic        commit_ack_i;
    logic        commit_rd_we_o;
    reg_idx_t    commit_rd_o;
    xlen_t       commit_value_o;

    logic [31:0] tdata [max_words];
    int          num_records;
    int          cur_record;
    bit          loaded;
    int          errors;
    int          checks;
    logic [31:0] lfsr_q;

    // commits seen on the retire link in arrival order
    logic        seen_rd_we [$];
    reg_idx_t    seen_rd [$];
    xlen_t       seen_value [$];

    wb_subsystem u_wb_subsystem (
        .clock         (clock),
        .reset         (reset),
        .req_i         (req_i),
        .ack_o         (ack_o),
        .rd_we_i       (rd_we_i),
        .rd_i          (rd_i),
        .reg_wdata_i   (reg_wdata_i),
        .csr_op_i      (csr_op_i),
        .csr_sel_i     (csr_sel_i),
        .csr_wdata_i   (csr_wdata_i),
        .is_mem_i      (is_mem_i),
        .is_store_i    (is_store_i),
        .mem_addr_i    (mem_addr_i),
        .store_data_i  (store_data_i),
        .rs_idx_i      (rs_idx_i),
        .rs_data_o     (rs_data_o),
        .commit_req_o  (commit_req_o),
        .commit_ack_i  (commit_ack_i),
        .commit_rd_we_o(commit_rd_we_o),
        .commit_rd_o   (commit_rd_o),
        .commit_value_o(commit_value_o)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_value(input string name, input xlen_t actual, input xlen_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s (record %0d): got %h, expected %h",
                     name, cur_record, actual, expected);
        end
    endtask

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            value = {value[30:0], lfsr_q[0]};
        end
    endtask

    // word 0 of the file is the record count
    function automatic xlen_t rec_word(input int r, input int k);
        int idx;
        idx = 1 + r * rec_words + k;
        return tdata[idx[8:0]];
    endfunction

    task automatic wait_ack(input logic level);
        do begin
            @(posedge clock);
        end while (ack_o !== level);
    endtask

    // full four-phase exchange that returns once ack is low again
    task automatic send_record(input int r);
        xlen_t op_word;
        op_word = rec_word(r, 3);
        @(posedge clock);
        #1;
        rd_we_i      = rec_word(r, 0) != '0;
        rd_i         = reg_idx_t'(rec_word(r, 1));
        reg_wdata_i  = rec_word(r, 2);
        csr_op_i     = csr_op_e'(op_word[2:0]);
        csr_sel_i    = csr_sel_t'(rec_word(r, 4));
        csr_wdata_i  = rec_word(r, 5);
        is_mem_i     = rec_word(r, 6) != '0;
        is_store_i   = rec_word(r, 7) != '0;
        mem_addr_i   = mem_addr_t'(rec_word(r, 8));
        store_data_i = rec_word(r, 9);
        req_i        = 1'b1;
        wait_ack(1'b1);
        #1;
        req_i = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic check_commit(input int r);
        int seen;
        seen = seen_value.size();
        if (seen != 1) begin
            errors++;
            $display("record %0d retired with %0d commits on the retire link instead of one",
                     r, seen);
        end
        if (seen > 0) begin
            check_value("commit_rd_we_o", xlen_t'(seen_rd_we.pop_front()), rec_word(r, 10));
            check_value("commit_rd_o", xlen_t'(seen_rd.pop_front()), rec_word(r, 11));
            check_value("commit_value_o", seen_value.pop_front(), rec_word(r, 12));
        end
    endtask

    task automatic check_register(input int r);
        #1;
        rs_idx_i = reg_idx_t'(rec_word(r, 13));
        @(posedge clock);
        check_value("rs_data_o", rs_data_o, rec_word(r, 14));
    endtask

    // retire side that acks each commit after 0 to 7 cycles
    initial begin : retire_monitor
        logic [31:0] delay;
        commit_ack_i = 1'b0;
        lfsr_q = 32'hd60d;
        forever begin
            @(posedge clock);
            if (commit_req_o === 1'b1) begin
                seen_rd_we.push_back(commit_rd_we_o);
                seen_rd.push_back(commit_rd_o);
                seen_value.push_back(commit_value_o);
                draw_bits(3, delay);
                repeat (delay[2:0]) @(posedge clock);
                #1;
                commit_ack_i = 1'b1;
                do begin
                    @(posedge clock);
                end while (commit_req_o === 1'b1);
                #1;
                commit_ack_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        int limit;
        cycles = 0;
        wait (loaded);
        limit = num_records * cycles_per_record;
        while (cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: %0d records not finished within %0d cycles", num_records, limit);
        $display("Testbench failed");
        $finish;
    end

    initial begin : main_sequence
        reset        = 1'b1;
        req_i        = 1'b0;
        rd_we_i      = 1'b0;
        rd_i         = '0;
        reg_wdata_i  = '0;
        csr_op_i     = csr_none;
        csr_sel_i    = '0;
        csr_wdata_i  = '0;
        is_mem_i     = 1'b0;
        is_store_i   = 1'b0;
        mem_addr_i   = '0;
        store_data_i = '0;
        rs_idx_i     = '0;
        errors       = 0;
        checks       = 0;
        cur_record   = 0;
        $readmemh("test/wb_testdata.hex", tdata);
        num_records = int'(tdata[0]);
        if (num_records <= 0 || 1 + num_records * rec_words > max_words) begin
            errors++;
            $display("test data file holds no usable record count");
            num_records = 0;
        end
        loaded = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int r = 0; r < num_records; r++) begin
            cur_record = r;
            send_record(r);
            check_commit(r);
            check_register(r);
        end
        if (seen_value.size() != 0) begin
            errors++;
            $display("%0d commits arrived that belong to no record", seen_value.size());
        end
        $display("records: %0d, checks: %0d, errors: %0d", num_records, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/wb_testdata.hex */
// first word is the record count, then one record per line, all hex
// rd_we rd reg_wdata csr_op csr_sel csr_wdata is_mem is_store mem_addr store_data
// exp_rd_we exp_rd exp_value rs_idx exp_rs_data
0f
// plain alu results
1 05 1234abcd 0 0 00000000 0 0 00 00000000 1 05 1234abcd 05 1234abcd
1 06 deadbeef 0 0 00000000 0 0 00 00000000 1 06 deadbeef 06 deadbeef
// store then load, stores commit with rd_we low and leave rd untouched
0 07 00000000 0 0 00000000 1 1 0a cafef00d 0 07 00000000 07 00000000
1 07 00000000 0 0 00000000 1 0 0a 00000000 1 07 cafef00d 07 cafef00d
0 00 00000000 0 0 00000000 1 1 3f 00000055 0 00 00000000 05 1234abcd
1 09 00000000 0 0 00000000 1 0 3f 00000000 1 09 00000055 09 00000055
// mscratch write, set, clear, then set with zero to read back
1 0a 00000000 1 3 a5a5a5a5 0 0 00 00000000 1 0a 00000000 0a 00000000
1 0b 00000000 2 3 0000ff00 0 0 00 00000000 1 0b a5a5a5a5 0b a5a5a5a5
1 0c 00000000 3 3 a0000005 0 0 00 00000000 1 0c a5a5ffa5 0c a5a5ffa5
1 0d 00000000 2 3 00000000 0 0 00 00000000 1 0d 05a5ffa0 0d 05a5ffa0
// mtvec is separate from mscratch
1 0e 00000000 1 1 00000100 0 0 00 00000000 1 0e 00000000 0e 00000000
// x0 write commits but x0 stays zero
1 00 ffffffff 0 0 00000000 0 0 00 00000000 1 00 ffffffff 00 00000000
1 1f 80000001 0 0 00000000 0 0 00 00000000 1 1f 80000001 1f 80000001
1 0f 00000000 3 1 00000000 0 0 00 00000000 1 0f 00000100 0f 00000100
// load from a word never written
1 05 00000000 0 0 00000000 1 0 21 00000000 1 05 00000000 05 00000000
